// ==== rv_pkg.sv ====
package rv_pkg;

  localparam int XLEN      = 64;
  localparam int ILEN      = 32;
  localparam int REG_IDX_W = 5;

  localparam logic [REG_IDX_W-1:0] A0_IDX = 5'd10; // abi a0

  // major opcodes
  localparam logic [6:0] OPC_OP     = 7'b0110011;
  localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
  localparam logic [6:0] OPC_LUI    = 7'b0110111;
  localparam logic [6:0] OPC_BRANCH = 7'b1100011;

  localparam logic [2:0] F3_ADD_SUB = 3'b000;
  localparam logic [2:0] F3_SLL     = 3'b001;
  localparam logic [2:0] F3_SLT     = 3'b010;
  localparam logic [2:0] F3_XOR     = 3'b100;
  localparam logic [2:0] F3_SRL     = 3'b101;
  localparam logic [2:0] F3_OR      = 3'b110;
  localparam logic [2:0] F3_AND     = 3'b111;
  localparam logic [2:0] F3_BEQ     = 3'b000;
  localparam logic [2:0] F3_BNE     = 3'b001;

  localparam logic [6:0] F7_SUB = 7'b0100000;

  typedef enum logic [3:0] {
    ALU_ADD,
    ALU_SUB,
    ALU_AND,
    ALU_OR,
    ALU_XOR,
    ALU_SLT,
    ALU_SLL,
    ALU_SRL,
    ALU_PASS_B // lui
  } alu_op_e;

  // one instruction word, viewed per format
  typedef union packed {
    struct packed {
      logic [6:0]           funct7;
      logic [REG_IDX_W-1:0] rs2;
      logic [REG_IDX_W-1:0] rs1;
      logic [2:0]           funct3;
      logic [REG_IDX_W-1:0] rd;
      logic [6:0]           opcode;
    } r_fmt;
    struct packed {
      logic [11:0]          imm;
      logic [REG_IDX_W-1:0] rs1;
      logic [2:0]           funct3;
      logic [REG_IDX_W-1:0] rd;
      logic [6:0]           opcode;
    } i_fmt;
    struct packed {
      logic                 imm_12;
      logic [5:0]           imm_10_5;
      logic [REG_IDX_W-1:0] rs2;
      logic [REG_IDX_W-1:0] rs1;
      logic [2:0]           funct3;
      logic [3:0]           imm_4_1;
      logic                 imm_11;
      logic [6:0]           opcode;
    } b_fmt;
    struct packed {
      logic [19:0]          imm_31_12;
      logic [REG_IDX_W-1:0] rd;
      logic [6:0]           opcode;
    } u_fmt;
  } instr_u;

  typedef struct packed {
    logic            valid;
    logic [XLEN-1:0] pc;
    instr_u          instr;
  } if_id_t;

  typedef struct packed {
    logic                 valid;
    logic [XLEN-1:0]      pc;
    instr_u               instr;
    logic [XLEN-1:0]      rs1_val;
    logic [XLEN-1:0]      rs2_val;
    logic [REG_IDX_W-1:0] rs1_idx;
    logic [REG_IDX_W-1:0] rs2_idx;
    logic [XLEN-1:0]      imm;
    alu_op_e              alu_op;
    logic                 src2_imm;  // operand 2 from imm
    logic                 branch;
    logic                 branch_ne; // bne, else beq
    logic                 wr_en;
    logic [REG_IDX_W-1:0] rd_idx;
  } id_ex_t;

  typedef struct packed {
    logic                 valid;
    logic [XLEN-1:0]      pc;
    instr_u               instr;
    logic                 wr_en;
    logic [REG_IDX_W-1:0] rd_idx;
    logic [XLEN-1:0]      result;
  } commit_t;

endpackage

// ==== fetch_unit.sv ====
`timescale 1ns/1ns

module fetch_unit #(
  parameter logic [rv_pkg::XLEN-1:0] RESET_PC = '0
) (
  input  logic                    clk,
  input  logic                    reset_i,
  input  logic [rv_pkg::ILEN-1:0] instr_i,   // same-cycle answer to pc_o
  input  logic                    redirect_i,
  input  logic [rv_pkg::XLEN-1:0] target_i,
  output logic [rv_pkg::XLEN-1:0] pc_o,
  output rv_pkg::if_id_t          if_id_o
);

  logic [rv_pkg::XLEN-1:0] pc_q;
  logic [rv_pkg::XLEN-1:0] pc_next;
  rv_pkg::if_id_t          if_id_q;

  // taken branch in execute wins over sequential fetch
  assign pc_next = redirect_i ? target_i : pc_q + rv_pkg::XLEN'(4);

  always_ff @(posedge clk) begin
    if (reset_i) begin
      pc_q <= RESET_PC;
    end else begin
      pc_q <= pc_next;
    end
  end

  always_ff @(posedge clk) begin
    if (reset_i) begin
      if_id_q.valid <= 1'b0;
    end else begin
      if_id_q.valid <= !redirect_i; // word fetched down the wrong path
    end
    if_id_q.pc    <= pc_q;
    if_id_q.instr <= instr_i;
  end

  assign pc_o    = pc_q;
  assign if_id_o = if_id_q;

endmodule

// ==== reg_file.sv ====
`timescale 1ns/1ns

module reg_file (
  input  logic                         clk,
  input  logic                         reset_i,
  input  logic [rv_pkg::REG_IDX_W-1:0] rs1_idx_i,
  input  logic [rv_pkg::REG_IDX_W-1:0] rs2_idx_i,
  output logic [rv_pkg::XLEN-1:0]      rs1_data_o,
  output logic [rv_pkg::XLEN-1:0]      rs2_data_o,
  input  rv_pkg::commit_t              wb_i,
  output logic [rv_pkg::XLEN-1:0]      a0_o
);

  logic [rv_pkg::XLEN-1:0] regs_q [1:31]; // x0 not stored
  logic                    wr_en;

  assign wr_en = wb_i.valid && wb_i.wr_en && (wb_i.rd_idx != '0);

  // read with write-before-read bypass
  function automatic logic [rv_pkg::XLEN-1:0] read_port(
    input logic [rv_pkg::REG_IDX_W-1:0] idx
  );
    if (idx == '0) begin
      return '0;
    end else if (wr_en && (idx == wb_i.rd_idx)) begin
      return wb_i.result;
    end
    return regs_q[idx];
  endfunction

  always_comb begin
    rs1_data_o = read_port(rs1_idx_i);
    rs2_data_o = read_port(rs2_idx_i);
    a0_o       = read_port(rv_pkg::A0_IDX); // difftest tap
  end

  always_ff @(posedge clk) begin
    if (reset_i) begin
      for (int i = 1; i < 32; i++) begin
        regs_q[i] <= '0;
      end
    end else if (wr_en) begin
      regs_q[wb_i.rd_idx] <= wb_i.result;
    end
  end

endmodule

// ==== decode_stage.sv ====
`timescale 1ns/1ns

module decode_stage (
  input  logic                         clk,
  input  logic                         reset_i,
  input  logic                         flush_i,
  input  rv_pkg::if_id_t               if_id_i,
  input  logic [rv_pkg::XLEN-1:0]      rs1_data_i,
  input  logic [rv_pkg::XLEN-1:0]      rs2_data_i,
  output logic [rv_pkg::REG_IDX_W-1:0] rs1_idx_o,
  output logic [rv_pkg::REG_IDX_W-1:0] rs2_idx_o,
  output rv_pkg::id_ex_t               id_ex_o
);

  rv_pkg::instr_u          ins;
  logic [rv_pkg::XLEN-1:0] imm_i_ext;
  logic [rv_pkg::XLEN-1:0] imm_b_ext;
  logic [rv_pkg::XLEN-1:0] imm_u_ext;
  logic [rv_pkg::XLEN-1:0] imm;
  rv_pkg::alu_op_e         alu_op;
  logic                    src2_imm;
  logic                    is_branch;
  logic                    branch_ne;
  logic                    wr_en;
  rv_pkg::id_ex_t          id_ex_q;

  assign ins       = if_id_i.instr;
  assign rs1_idx_o = ins.r_fmt.rs1;
  assign rs2_idx_o = ins.r_fmt.rs2;

  assign imm_i_ext = {{(rv_pkg::XLEN-12){ins.i_fmt.imm[11]}}, ins.i_fmt.imm};
  assign imm_b_ext = {{(rv_pkg::XLEN-13){ins.b_fmt.imm_12}}, ins.b_fmt.imm_12,
                      ins.b_fmt.imm_11, ins.b_fmt.imm_10_5, ins.b_fmt.imm_4_1, 1'b0};
  assign imm_u_ext = {{(rv_pkg::XLEN-32){ins.u_fmt.imm_31_12[19]}},
                      ins.u_fmt.imm_31_12, 12'b0};

  always_comb begin
    alu_op    = rv_pkg::ALU_ADD;
    src2_imm  = 1'b0;
    is_branch = 1'b0;
    branch_ne = 1'b0;
    wr_en     = 1'b0;
    imm       = imm_i_ext;
    case (ins.r_fmt.opcode)
      rv_pkg::OPC_OP: begin
        wr_en = 1'b1;
        case (ins.r_fmt.funct3)
          rv_pkg::F3_ADD_SUB: begin
            if (ins.r_fmt.funct7 == rv_pkg::F7_SUB) begin
              alu_op = rv_pkg::ALU_SUB;
            end
          end
          rv_pkg::F3_SLL: alu_op = rv_pkg::ALU_SLL;
          rv_pkg::F3_SLT: alu_op = rv_pkg::ALU_SLT;
          rv_pkg::F3_XOR: alu_op = rv_pkg::ALU_XOR;
          rv_pkg::F3_SRL: alu_op = rv_pkg::ALU_SRL;
          rv_pkg::F3_OR:  alu_op = rv_pkg::ALU_OR;
          rv_pkg::F3_AND: alu_op = rv_pkg::ALU_AND;
          default:        wr_en  = 1'b0; // sltu
        endcase
        // only sub may carry a nonzero funct7 (sra, mul not kept)
        if (ins.r_fmt.funct7 != '0 &&
            !(ins.r_fmt.funct7 == rv_pkg::F7_SUB && ins.r_fmt.funct3 == rv_pkg::F3_ADD_SUB)) begin
          wr_en = 1'b0;
        end
      end
      rv_pkg::OPC_OP_IMM: begin
        wr_en    = 1'b1;
        src2_imm = 1'b1;
        case (ins.i_fmt.funct3)
          rv_pkg::F3_ADD_SUB: alu_op = rv_pkg::ALU_ADD;
          rv_pkg::F3_SLT:     alu_op = rv_pkg::ALU_SLT;
          rv_pkg::F3_XOR:     alu_op = rv_pkg::ALU_XOR;
          rv_pkg::F3_OR:      alu_op = rv_pkg::ALU_OR;
          rv_pkg::F3_AND:     alu_op = rv_pkg::ALU_AND;
          rv_pkg::F3_SLL:     alu_op = rv_pkg::ALU_SLL;
          rv_pkg::F3_SRL:     alu_op = rv_pkg::ALU_SRL;
          default:            wr_en  = 1'b0;
        endcase
        // upper six bits must be zero for slli/srli, srai dropped
        if ((ins.i_fmt.funct3 == rv_pkg::F3_SLL || ins.i_fmt.funct3 == rv_pkg::F3_SRL) &&
            ins.i_fmt.imm[11:6] != '0) begin
          wr_en = 1'b0;
        end
      end
      rv_pkg::OPC_LUI: begin
        wr_en    = 1'b1;
        src2_imm = 1'b1;
        alu_op   = rv_pkg::ALU_PASS_B;
        imm      = imm_u_ext;
      end
      rv_pkg::OPC_BRANCH: begin
        imm       = imm_b_ext;
        is_branch = (ins.b_fmt.funct3 == rv_pkg::F3_BEQ) ||
                    (ins.b_fmt.funct3 == rv_pkg::F3_BNE);
        branch_ne = (ins.b_fmt.funct3 == rv_pkg::F3_BNE);
      end
      default: ; // committed as a no-op
    endcase
  end

  always_ff @(posedge clk) begin
    if (reset_i || flush_i) begin
      id_ex_q.valid <= 1'b0;
    end else begin
      id_ex_q.valid <= if_id_i.valid;
    end
    id_ex_q.pc        <= if_id_i.pc;
    id_ex_q.instr     <= ins;
    id_ex_q.rs1_val   <= rs1_data_i;
    id_ex_q.rs2_val   <= rs2_data_i;
    id_ex_q.rs1_idx   <= ins.r_fmt.rs1;
    id_ex_q.rs2_idx   <= ins.r_fmt.rs2;
    id_ex_q.imm       <= imm;
    id_ex_q.alu_op    <= alu_op;
    id_ex_q.src2_imm  <= src2_imm;
    id_ex_q.branch    <= is_branch;
    id_ex_q.branch_ne <= branch_ne;
    id_ex_q.wr_en     <= wr_en;
    id_ex_q.rd_idx    <= ins.r_fmt.rd;
  end

  assign id_ex_o = id_ex_q;

endmodule

// ==== execute_stage.sv ====
`timescale 1ns/1ns

module execute_stage (
  input  logic                    clk,
  input  logic                    reset_i,
  input  rv_pkg::id_ex_t          id_ex_i,
  output logic                    redirect_o,
  output logic [rv_pkg::XLEN-1:0] target_o,
  output rv_pkg::commit_t         commit_o
);

  rv_pkg::commit_t         commit_q;
  logic                    fwd_ok;
  logic                    fwd_rs1;
  logic                    fwd_rs2;
  logic [rv_pkg::XLEN-1:0] rs1_val;
  logic [rv_pkg::XLEN-1:0] rs2_val;
  logic [rv_pkg::XLEN-1:0] op_a;
  logic [rv_pkg::XLEN-1:0] op_b;
  logic [5:0]              shamt;
  logic [rv_pkg::XLEN-1:0] alu_res;
  logic                    rs_equal;
  logic                    taken;

  // result one ahead still sits in commit_q, older ones come via the bypass
  assign fwd_ok  = commit_q.valid && commit_q.wr_en && (commit_q.rd_idx != '0);
  assign fwd_rs1 = fwd_ok && (commit_q.rd_idx == id_ex_i.rs1_idx);
  assign fwd_rs2 = fwd_ok && (commit_q.rd_idx == id_ex_i.rs2_idx);

  assign rs1_val = fwd_rs1 ? commit_q.result : id_ex_i.rs1_val;
  assign rs2_val = fwd_rs2 ? commit_q.result : id_ex_i.rs2_val;

  assign op_a  = rs1_val;
  assign op_b  = id_ex_i.src2_imm ? id_ex_i.imm : rs2_val;
  assign shamt = op_b[5:0]; // rv64 shift amount

  always_comb begin
    case (id_ex_i.alu_op)
      rv_pkg::ALU_ADD:    alu_res = op_a + op_b;
      rv_pkg::ALU_SUB:    alu_res = op_a - op_b;
      rv_pkg::ALU_AND:    alu_res = op_a & op_b;
      rv_pkg::ALU_OR:     alu_res = op_a | op_b;
      rv_pkg::ALU_XOR:    alu_res = op_a ^ op_b;
      rv_pkg::ALU_SLT: begin
        alu_res = {{(rv_pkg::XLEN-1){1'b0}}, ($signed(op_a) < $signed(op_b))};
      end
      rv_pkg::ALU_SLL:    alu_res = op_a << shamt;
      rv_pkg::ALU_SRL:    alu_res = op_a >> shamt;
      rv_pkg::ALU_PASS_B: alu_res = op_b;
      default:            alu_res = op_a + op_b;
    endcase
  end

  // branches compare the two registers, never the immediate
  assign rs_equal = (rs1_val == rs2_val);
  assign taken    = id_ex_i.branch && (id_ex_i.branch_ne ? !rs_equal : rs_equal);

  assign redirect_o = id_ex_i.valid && taken; // also flushes fetch and decode
  assign target_o   = id_ex_i.pc + id_ex_i.imm;

  always_ff @(posedge clk) begin
    if (reset_i) begin
      commit_q.valid <= 1'b0;
    end else begin
      commit_q.valid <= id_ex_i.valid;
    end
    commit_q.pc     <= id_ex_i.pc;
    commit_q.instr  <= id_ex_i.instr;
    commit_q.wr_en  <= id_ex_i.wr_en; // zero for branches
    commit_q.rd_idx <= id_ex_i.rd_idx;
    commit_q.result <= alu_res;
  end

  assign commit_o = commit_q;

endmodule

// ==== pipeline_top.sv ====
`timescale 1ns/1ns

module pipeline_top #(
  parameter logic [rv_pkg::XLEN-1:0] RESET_PC = '0
) (
  input  logic                    clk,
  input  logic                    reset_i,
  input  logic [rv_pkg::ILEN-1:0] instr_i,
  output logic [rv_pkg::XLEN-1:0] pc_o,
  output logic                    commit_valid_o,
  output logic [rv_pkg::XLEN-1:0] commit_pc_o,
  output logic [rv_pkg::ILEN-1:0] commit_instr_o,
  output logic [rv_pkg::XLEN-1:0] a0_o
);

  rv_pkg::if_id_t               if_id;
  rv_pkg::id_ex_t               id_ex;
  rv_pkg::commit_t              commit;
  logic                         redirect; // branch flush
  logic [rv_pkg::XLEN-1:0]      target;
  logic [rv_pkg::REG_IDX_W-1:0] rs1_idx;
  logic [rv_pkg::REG_IDX_W-1:0] rs2_idx;
  logic [rv_pkg::XLEN-1:0]      rs1_data;
  logic [rv_pkg::XLEN-1:0]      rs2_data;

  fetch_unit #(.RESET_PC(RESET_PC)) u_fetch_unit (
    .clk        (clk),
    .reset_i    (reset_i),
    .instr_i    (instr_i),
    .redirect_i (redirect),
    .target_i   (target),
    .pc_o       (pc_o),
    .if_id_o    (if_id)
  );

  decode_stage u_decode_stage (
    .clk        (clk),
    .reset_i    (reset_i),
    .flush_i    (redirect),
    .if_id_i    (if_id),
    .rs1_data_i (rs1_data),
    .rs2_data_i (rs2_data),
    .rs1_idx_o  (rs1_idx),
    .rs2_idx_o  (rs2_idx),
    .id_ex_o    (id_ex)
  );

  reg_file u_reg_file (
    .clk        (clk),
    .reset_i    (reset_i),
    .rs1_idx_i  (rs1_idx),
    .rs2_idx_i  (rs2_idx),
    .rs1_data_o (rs1_data),
    .rs2_data_o (rs2_data),
    .wb_i       (commit),
    .a0_o       (a0_o)
  );

  execute_stage u_execute_stage (
    .clk        (clk),
    .reset_i    (reset_i),
    .id_ex_i    (id_ex),
    .redirect_o (redirect),
    .target_o   (target),
    .commit_o   (commit)
  );

  // difftest view of the commit point
  assign commit_valid_o = commit.valid;
  assign commit_pc_o    = commit.pc;
  assign commit_instr_o = commit.instr;

endmodule

// ==== tb_pipeline_checker.sv ====
`timescale 1ns/1ns

module tb_pipeline_checker (
  input logic                    clk,
  input logic                    reset_i,
  input logic                    redirect_i,
  input logic                    commit_valid_i,
  input logic [rv_pkg::XLEN-1:0] commit_pc_i,
  input logic [rv_pkg::XLEN-1:0] a0_i
);

  logic                    taken_q;      // entry on commit is a taken branch
  logic                    seen_q;       // a commit since reset
  logic                    last_taken_q;
  logic [rv_pkg::XLEN-1:0] last_pc_q;
  int unsigned             fail_cnt = 0; // assertion failures so far

  always_ff @(posedge clk) begin
    if (reset_i) begin
      taken_q      <= 1'b0;
      seen_q       <= 1'b0;
      last_taken_q <= 1'b0;
      last_pc_q    <= '0;
    end else begin
      taken_q <= redirect_i; // branch resolves one cycle before it commits
      if (commit_valid_i) begin
        seen_q       <= 1'b1;
        last_taken_q <= taken_q;
        last_pc_q    <= commit_pc_i;
      end
    end
  end

  a_idle_after_reset: assert property (@(posedge clk) reset_i |=> !commit_valid_i)
    else begin
      $error("commit valid in the cycle after reset");
      fail_cnt++;
    end

  a_pc_step: assert property (@(posedge clk) disable iff (reset_i)
    commit_valid_i && seen_q && !last_taken_q |-> commit_pc_i == last_pc_q + 4)
    else begin
      $error("commit pc did not advance by 4 after a sequential commit");
      fail_cnt++;
    end

  a_a0_known: assert property (@(posedge clk) disable iff (reset_i) !$isunknown(a0_i))
    else begin
      $error("a0 is unknown after reset");
      fail_cnt++;
    end

endmodule

// ==== tb_pipeline.sv ====
`timescale 1ns/1ns

module tb_pipeline;

  localparam int                      XLEN       = rv_pkg::XLEN;
  localparam logic [rv_pkg::XLEN-1:0] RESET_PC   = '0;
  localparam int                      IMEM_WORDS = 64;
  localparam int                      CLK_HALF   = 50;
  localparam int                      DRIVE_DLY  = 10;
  localparam int                      TEST_SLACK = 20; // cycles per test beyond program length
  localparam logic [31:0]             SEED       = 32'h312c_7563;
  localparam logic [4:0]              A0         = rv_pkg::A0_IDX;

  logic                    clk;
  logic                    reset_i;
  logic [rv_pkg::ILEN-1:0] instr;
  logic [XLEN-1:0]         pc;
  logic                    commit_valid;
  logic [XLEN-1:0]         commit_pc;
  logic [rv_pkg::ILEN-1:0] commit_instr;
  logic [XLEN-1:0]         a0;

  logic [31:0]     imem [IMEM_WORDS];
  int              prog_len;
  logic [XLEN-1:0] ref_regs [32];
  logic [XLEN-1:0] exp_pcs [$]; // commit order from the reference model
  logic [XLEN-1:0] exp_a0;
  int              cycle_cnt   = 0;
  int              cycle_limit = 0;

  pipeline_top #(.RESET_PC(RESET_PC)) u_pipeline_top (
    .clk            (clk),
    .reset_i        (reset_i),
    .instr_i        (instr),
    .pc_o           (pc),
    .commit_valid_o (commit_valid),
    .commit_pc_o    (commit_pc),
    .commit_instr_o (commit_instr),
    .a0_o           (a0)
  );

  bind pipeline_top tb_pipeline_checker u_pipeline_checker (
    .clk            (clk),
    .reset_i        (reset_i),
    .redirect_i     (redirect),
    .commit_valid_i (commit_valid_o),
    .commit_pc_i    (commit_pc_o),
    .a0_i           (a0_o)
  );

  initial begin
    clk = 1'b0;
    forever #CLK_HALF clk = ~clk;
  end

  always @(posedge clk) begin
    cycle_cnt++;
    if (cycle_cnt > cycle_limit) begin
      $display("timeout: the tests did not finish within %0d cycles", cycle_limit);
      $display("Simulation failed");
      $fatal(1, "cycle limit reached");
    end else if (u_pipeline_top.u_pipeline_checker.fail_cnt != 0) begin
      $display("an assertion in the bound checker failed");
      $display("Simulation failed");
      $fatal(1, "assertion failure");
    end
  end

  // unused words hold an unsupported opcode, so they commit as no-ops
  function automatic logic [31:0] filler_word(input logic [XLEN-1:0] addr);
    logic [24:0] h;
    h = addr[26:2] ^ addr[51:27] ^ {11'b0, addr[63:52], addr[1:0]};
    return {h, 7'h7f};
  endfunction

  always_comb begin
    if (pc < XLEN'(IMEM_WORDS * 4)) begin
      instr = imem[pc[7:2]];
    end else begin
      instr = filler_word(pc);
    end
  end

  function automatic logic [31:0] enc_r(input logic [6:0] f7, input logic [2:0] f3,
                                        input logic [4:0] rd, input logic [4:0] rs1,
                                        input logic [4:0] rs2);
    return {f7, rs2, rs1, f3, rd, rv_pkg::OPC_OP};
  endfunction

  function automatic logic [31:0] enc_i(input logic [2:0] f3, input logic [4:0] rd,
                                        input logic [4:0] rs1, input logic [11:0] imm);
    return {imm, rs1, f3, rd, rv_pkg::OPC_OP_IMM};
  endfunction

  function automatic logic [31:0] enc_lui(input logic [4:0] rd, input logic [19:0] upper);
    return {upper, rd, rv_pkg::OPC_LUI};
  endfunction

  function automatic logic [31:0] enc_b(input logic [2:0] f3, input logic [4:0] rs1,
                                        input logic [4:0] rs2, input logic [12:0] off);
    return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], rv_pkg::OPC_BRANCH};
  endfunction

  task automatic check(input string test, input string what,
                       input logic [XLEN-1:0] exp_val, input logic [XLEN-1:0] act_val);
    if (act_val !== exp_val) begin
      $display("Fail %s (%s): expected %h, actual %h", test, what, exp_val, act_val);
      $display("Simulation failed");
      $fatal(1, "value mismatch");
    end
  endtask

  task automatic begin_program;
    for (int i = 0; i < IMEM_WORDS; i++) begin
      imem[i] = filler_word(XLEN'(i * 4));
    end
    prog_len = 0;
  endtask

  task automatic emit(input logic [31:0] word);
    imem[prog_len] = word;
    prog_len++;
  endtask

  task automatic apply_reset;
    @(posedge clk);
    #DRIVE_DLY;
    reset_i = 1'b1;
    repeat (3) @(posedge clk);
    #DRIVE_DLY;
    reset_i = 1'b0;
  endtask

  // one instruction of the reference ISA model, decoded from raw bit fields
  task automatic exec_ref(input logic [31:0] ins, inout logic [XLEN-1:0] ref_pc);
    logic [4:0]      rd;
    logic [2:0]      f3;
    logic [XLEN-1:0] a;
    logic [XLEN-1:0] b;
    logic [XLEN-1:0] imm;
    logic [XLEN-1:0] res;
    logic            wr;
    rd     = ins[11:7];
    f3     = ins[14:12];
    a      = ref_regs[ins[19:15]];
    b      = ref_regs[ins[24:20]];
    imm    = {{52{ins[31]}}, ins[31:20]};
    res    = '0;
    wr     = 1'b0;
    ref_pc = ref_pc + 4;
    case (ins[6:0])
      7'b0110011: begin
        if (ins[31:25] == 7'b0000000) begin
          wr = 1'b1;
          case (f3)
            3'b000:  res = a + b;
            3'b001:  res = a << b[5:0];
            3'b010:  res = XLEN'($signed(a) < $signed(b));
            3'b100:  res = a ^ b;
            3'b101:  res = a >> b[5:0];
            3'b110:  res = a | b;
            3'b111:  res = a & b;
            default: wr = 1'b0; // sltu not kept
          endcase
        end else if (ins[31:25] == 7'b0100000 && f3 == 3'b000) begin
          wr  = 1'b1;
          res = a - b;
        end
      end
      7'b0010011: begin
        wr = 1'b1;
        case (f3)
          3'b000:  res = a + imm;
          3'b010:  res = XLEN'($signed(a) < $signed(imm));
          3'b100:  res = a ^ imm;
          3'b110:  res = a | imm;
          3'b111:  res = a & imm;
          3'b001:  res = a << ins[25:20];
          3'b101:  res = a >> ins[25:20];
          default: wr = 1'b0;
        endcase
        if ((f3 == 3'b001 || f3 == 3'b101) && ins[31:26] != 6'b0) begin
          wr = 1'b0;
        end
      end
      7'b0110111: begin
        wr  = 1'b1;
        res = {{32{ins[31]}}, ins[31:12], 12'b0};
      end
      7'b1100011: begin
        imm = {{51{ins[31]}}, ins[31], ins[7], ins[30:25], ins[11:8], 1'b0};
        if ((f3 == 3'b000 && a == b) || (f3 == 3'b001 && a != b)) begin
          ref_pc = ref_pc - 4 + imm;
        end
      end
      default: ;
    endcase
    if (wr && rd != 5'd0) begin
      ref_regs[rd] = res;
    end
  endtask

  task automatic run_reference;
    logic [XLEN-1:0] ref_pc;
    int              steps;
    foreach (ref_regs[i]) begin
      ref_regs[i] = '0;
    end
    exp_pcs.delete();
    ref_pc = RESET_PC;
    steps  = 0;
    while (ref_pc < XLEN'(prog_len * 4) && steps < 4 * IMEM_WORDS) begin
      exp_pcs.push_back(ref_pc);
      exec_ref(imem[ref_pc[7:2]], ref_pc);
      steps++;
    end
    exp_a0 = ref_regs[A0];
  endtask

  // reset, then follow commits until the reference's last pc shows up
  task automatic run_and_compare(input string test);
    int              idx;
    int              gap;
    int              exp_gap;
    logic [XLEN-1:0] cur_pc;
    run_reference();
    cycle_limit += prog_len + TEST_SLACK;
    apply_reset();
    idx = 0;
    gap = 0;
    while (idx < exp_pcs.size()) begin
      @(negedge clk);
      gap++;
      if (commit_valid) begin
        cur_pc = exp_pcs[idx];
        check(test, "commit pc", cur_pc, commit_pc);
        check(test, "commit instr", XLEN'(imem[cur_pc[7:2]]), XLEN'(commit_instr));
        if (idx == 0) begin
          exp_gap = 4; // three edges through the pipe
        end else if (cur_pc == exp_pcs[idx-1] + 4) begin
          exp_gap = 1;
        end else begin
          exp_gap = 3; // two bubbles after a taken branch
        end
        check(test, "commit spacing", XLEN'(exp_gap), XLEN'(gap));
        gap = 0;
        idx++;
      end
    end
    check(test, "a0", exp_a0, a0);
  endtask

  task automatic reset_test;
    begin_program();
    cycle_limit += TEST_SLACK;
    apply_reset();
    for (int i = 0; i < 3; i++) begin
      @(negedge clk);
      if (i == 0) begin
        check("reset", "pc", RESET_PC, pc);
        check("reset", "a0", '0, a0);
      end
      check("reset", "commit valid low", '0, XLEN'(commit_valid));
    end
    @(negedge clk);
    check("reset", "first commit valid", 1, XLEN'(commit_valid));
    check("reset", "first commit pc", RESET_PC, commit_pc);
  endtask

  task automatic alu_imm_test;
    logic [11:0] imm [6];
    logic [19:0] upper;
    logic [5:0]  sh1;
    logic [5:0]  sh2;
    foreach (imm[i]) begin
      imm[i] = 12'($urandom);
    end
    upper = 20'($urandom);
    sh1   = 6'($urandom);
    sh2   = 6'($urandom);
    begin_program();
    emit(enc_i(rv_pkg::F3_ADD_SUB, 5'd5, 5'd0, imm[0]));
    emit(enc_i(rv_pkg::F3_ADD_SUB, 5'd6, 5'd0, imm[1]));
    emit(enc_lui(5'd7, upper));
    emit(enc_i(rv_pkg::F3_OR, 5'd8, 5'd0, imm[2]));
    emit(enc_i(rv_pkg::F3_AND, 5'd9, 5'd6, imm[3]));
    emit(enc_i(rv_pkg::F3_XOR, 5'd11, 5'd5, imm[4]));
    emit(enc_i(rv_pkg::F3_SLT, 5'd12, 5'd5, imm[5]));
    emit(enc_i(rv_pkg::F3_SLL, 5'd13, 5'd6, {6'b0, sh1}));
    emit(enc_i(rv_pkg::F3_SRL, 5'd14, 5'd7, {6'b0, sh2}));
    emit(enc_r(7'b0, rv_pkg::F3_ADD_SUB, A0, 5'd5, 5'd6));
    emit(enc_r(rv_pkg::F7_SUB, rv_pkg::F3_ADD_SUB, A0, A0, 5'd7));
    emit(enc_r(7'b0, rv_pkg::F3_AND, 5'd15, 5'd8, 5'd9));
    emit(enc_r(7'b0, rv_pkg::F3_OR, 5'd16, 5'd11, 5'd12));
    emit(enc_r(7'b0, rv_pkg::F3_SLT, 5'd17, 5'd7, 5'd5));
    emit(enc_r(7'b0, rv_pkg::F3_SLL, 5'd18, 5'd6, 5'd8));
    emit(enc_r(7'b0, rv_pkg::F3_SRL, 5'd19, 5'd7, 5'd9));
    emit(enc_r(7'b0, rv_pkg::F3_XOR, A0, A0, 5'd13)); // fold everything into a0
    emit(enc_r(7'b0, rv_pkg::F3_ADD_SUB, A0, A0, 5'd14));
    emit(enc_r(7'b0, rv_pkg::F3_XOR, A0, A0, 5'd15));
    emit(enc_r(7'b0, rv_pkg::F3_ADD_SUB, A0, A0, 5'd16));
    emit(enc_r(7'b0, rv_pkg::F3_ADD_SUB, A0, A0, 5'd17));
    emit(enc_r(7'b0, rv_pkg::F3_XOR, A0, A0, 5'd18));
    emit(enc_r(7'b0, rv_pkg::F3_ADD_SUB, A0, A0, 5'd19));
    run_and_compare("alu_imm");
  endtask

  task automatic forwarding_test;
    logic [11:0] imm [5];
    foreach (imm[i]) begin
      imm[i] = 12'($urandom);
    end
    begin_program();
    emit(enc_i(rv_pkg::F3_ADD_SUB, 5'd5, 5'd0, imm[0]));
    emit(enc_i(rv_pkg::F3_ADD_SUB, 5'd5, 5'd5, imm[1]));      // distance one
    emit(enc_r(7'b0, rv_pkg::F3_ADD_SUB, 5'd6, 5'd5, 5'd5));   // both operands forwarded
    emit(enc_r(rv_pkg::F7_SUB, rv_pkg::F3_ADD_SUB, 5'd7, 5'd6, 5'd5)); // rs2 via bypass
    emit(enc_r(7'b0, rv_pkg::F3_XOR, 5'd8, 5'd7, 5'd6));
    emit(enc_i(rv_pkg::F3_ADD_SUB, 5'd20, 5'd0, imm[2]));
    emit(enc_i(rv_pkg::F3_ADD_SUB, 5'd21, 5'd0, imm[3]));
    emit(enc_r(7'b0, rv_pkg::F3_SLL, 5'd22, 5'd20, 5'd21));
    emit(enc_r(7'b0, rv_pkg::F3_ADD_SUB, A0, 5'd8, 5'd22));
    emit(enc_i(rv_pkg::F3_XOR, A0, A0, imm[4]));
    emit(enc_r(7'b0, rv_pkg::F3_OR, A0, A0, 5'd5));
    run_and_compare("forwarding");
  endtask

  task automatic branch_test;
    begin_program();
    emit(enc_i(rv_pkg::F3_ADD_SUB, 5'd5, 5'd0, 12'd7));
    emit(enc_i(rv_pkg::F3_ADD_SUB, 5'd6, 5'd0, 12'd7));
    emit(enc_b(rv_pkg::F3_BEQ, 5'd5, 5'd6, 13'd12));          // taken to word 5
    emit(enc_i(rv_pkg::F3_ADD_SUB, A0, 5'd0, 12'd111));        // killed
    emit(enc_i(rv_pkg::F3_ADD_SUB, A0, A0, 12'd222));          // killed
    emit(enc_i(rv_pkg::F3_ADD_SUB, A0, 5'd0, 12'd5));
    emit(enc_b(rv_pkg::F3_BNE, 5'd5, 5'd6, 13'd12));           // falls through
    emit(enc_i(rv_pkg::F3_ADD_SUB, A0, A0, 12'd3));
    emit(enc_b(rv_pkg::F3_BNE, A0, 5'd5, 13'd8));              // uses forwarded a0
    emit(enc_i(rv_pkg::F3_ADD_SUB, A0, 5'd0, 12'd999));
    emit(enc_i(rv_pkg::F3_ADD_SUB, A0, A0, 12'd1));
    emit(enc_b(rv_pkg::F3_BEQ, 5'd5, 5'd0, 13'd8));
    emit(enc_i(rv_pkg::F3_ADD_SUB, A0, A0, 12'd16));
    run_and_compare("branch");
  endtask

  task automatic x0_unsupported_test;
    logic [11:0] imm_a;
    logic [11:0] imm_b;
    logic [19:0] junk;
    imm_a = 12'($urandom);
    imm_b = 12'($urandom);
    junk  = 20'($urandom);
    begin_program();
    emit(enc_i(rv_pkg::F3_ADD_SUB, 5'd5, 5'd0, imm_a));
    emit(enc_i(rv_pkg::F3_ADD_SUB, 5'd0, 5'd0, imm_b));
    emit(enc_r(7'b0, rv_pkg::F3_ADD_SUB, 5'd0, 5'd5, 5'd5));
    emit(enc_lui(5'd0, junk));
    emit(enc_i(rv_pkg::F3_ADD_SUB, A0, 5'd0, 12'd77));
    emit({junk, A0, 7'b0001011});                             // custom-0 opcode aimed at a0
    emit(enc_r(7'b0, 3'b011, A0, 5'd5, 5'd0));                 // sltu is not kept
    emit(enc_r(7'b0, rv_pkg::F3_ADD_SUB, 5'd11, A0, 5'd0));
    emit(enc_r(7'b0, rv_pkg::F3_ADD_SUB, A0, 5'd0, 5'd0));     // a0 = x0
    emit(enc_r(7'b0, rv_pkg::F3_ADD_SUB, A0, A0, 5'd11));
    run_and_compare("x0_unsupported");
  endtask

  initial begin
    reset_i = 1'b1;
    void'($urandom(SEED));
    reset_test();
    alu_imm_test();
    forwarding_test();
    branch_test();
    x0_unsupported_test();
    if (u_pipeline_top.u_pipeline_checker.fail_cnt == 0) begin
      $display("Simulation passed");
      $finish;
    end else begin
      $display("an assertion in the bound checker failed");
      $display("Simulation failed");
      $fatal(1, "assertion failure");
    end
  end

endmodule

// ==== compile.f ====
rv_pkg.sv
fetch_unit.sv
reg_file.sv
decode_stage.sv
execute_stage.sv
pipeline_top.sv
tb_pipeline_checker.sv
tb_pipeline.sv
